//--- logic/issue_pkg.sv
package issue_pkg;

    parameter int xlen  = 32;
    parameter int tag_w = 6;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_sll = 3'd5
    } alu_op_e;

    typedef struct packed {
        logic [xlen-tag_w-1:0] pad;
        logic [tag_w-1:0]      tag; // physical register tag
    } tag_view_t;

    // operand word, read as data once is_value is set, else as a tag
    typedef union packed {
        logic [xlen-1:0] data;
        tag_view_t       tv;
    } operand_u;

    typedef struct packed {
        logic     is_value;
        operand_u val;
    } operand_t;

    typedef struct packed {
        logic             valid;
        alu_op_e          op;
        operand_t         opa;
        operand_t         opb;
        logic [tag_w-1:0] dest_tag;
    } dispatch_t;

    typedef struct packed {
        logic             valid;
        alu_op_e          op;
        logic [xlen-1:0]  opa;
        logic [xlen-1:0]  opb;
        logic [tag_w-1:0] dest_tag;
    } issue_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  data;
    } cdb_t;

    function automatic logic [xlen-1:0] alu_compute(
        input alu_op_e         op,
        input logic [xlen-1:0] a,
        input logic [xlen-1:0] b
    );
        case (op)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            alu_sll: return a << b[4:0]; // low 5 bits only
            default: return '0;
        endcase
    endfunction

endpackage

//--- logic/rs_line.sv
module rs_line #(
    parameter int cdb_ways = 2
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 load,
    input  issue_pkg::dispatch_t entry,
    input  issue_pkg::cdb_t      cdb [cdb_ways],
    input  logic                 clear,
    output logic                 ready,
    output logic                 is_free,
    output issue_pkg::issue_t    slot
);
    import issue_pkg::*;

    logic             occupied;
    alu_op_e          op_q;
    logic [tag_w-1:0] dest_q;
    operand_t         opa_q;
    operand_t         opb_q;
    operand_t         opa_src;
    operand_t         opb_src;
    operand_t         opa_nxt;
    operand_t         opb_nxt;

    // capture the value of a waiting tag from any valid way
    function automatic operand_t snoop(
        input operand_t src,
        input cdb_t     bus [cdb_ways]
    );
        operand_t res;
        res = src;
        for (int w = 0; w < cdb_ways; w++) begin
            if (!src.is_value && bus[w].valid && bus[w].tag == src.val.tv.tag) begin
                res.is_value = 1'b1;
                res.val.data = bus[w].data;
            end
        end
        return res;
    endfunction

    // incoming operands are snooped too, so a same-cycle broadcast is caught
    assign opa_src = load ? entry.opa : opa_q;
    assign opb_src = load ? entry.opb : opb_q;

    always_comb begin
        opa_nxt = snoop(opa_src, cdb);
        opb_nxt = snoop(opb_src, cdb);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            occupied <= 1'b0;
        end else if (load) begin
            occupied <= 1'b1;
        end else if (clear) begin
            occupied <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            op_q   <= entry.op;
            dest_q <= entry.dest_tag;
        end
        if (load || occupied) begin
            opa_q <= opa_nxt;
            opb_q <= opb_nxt;
        end
    end

    assign is_free = !occupied;
    assign ready   = occupied && opa_q.is_value && opb_q.is_value;

    always_comb begin
        slot.valid    = ready;
        slot.op       = op_q;
        slot.opa      = opa_q.val.data;
        slot.opb      = opb_q.val.data;
        slot.dest_tag = dest_q;
    end

endmodule

//--- logic/rs_bank.sv
module rs_bank #(
    parameter int rs_depth = 8,
    parameter int num_alu  = 3,
    parameter int cdb_ways = 2
) (
    input  logic                 clock,
    input  logic                 reset,
    input  issue_pkg::dispatch_t dispatch,
    input  issue_pkg::cdb_t      cdb [cdb_ways],
    input  logic [num_alu-1:0]   alu_busy,
    output issue_pkg::issue_t    issue [num_alu],
    output logic                 credit_return
);
    import issue_pkg::*;

    logic [rs_depth-1:0] line_load;
    logic [rs_depth-1:0] line_clear;
    logic [rs_depth-1:0] line_ready;
    logic [rs_depth-1:0] line_free;
    issue_t              slot [rs_depth];
    issue_t              sel_slot;
    logic [num_alu-1:0]  alu_pick;
    logic                free_found;
    logic                rdy_found;
    logic                alu_found;
    logic                fire;

    for (genvar i = 0; i < rs_depth; i++) begin : g_line
        rs_line #(
            .cdb_ways (cdb_ways)
        ) i_rs_line (
            .clock   (clock),
            .reset   (reset),
            .load    (line_load[i]),
            .entry   (dispatch),
            .cdb     (cdb),
            .clear   (line_clear[i]),
            .ready   (line_ready[i]),
            .is_free (line_free[i]),
            .slot    (slot[i])
        );
    end

    // lowest free line takes the dispatch
    always_comb begin
        line_load  = '0;
        free_found = 1'b0;
        for (int i = 0; i < rs_depth; i++) begin
            if (line_free[i] && !free_found) begin
                line_load[i] = dispatch.valid;
                free_found   = 1'b1;
            end
        end
    end

    always_comb begin
        alu_pick  = '0;
        alu_found = 1'b0;
        for (int a = 0; a < num_alu; a++) begin
            if (!alu_busy[a] && !alu_found) begin
                alu_pick[a] = 1'b1;
                alu_found   = 1'b1;
            end
        end
        sel_slot   = '0;
        line_clear = '0;
        rdy_found  = 1'b0;
        for (int i = 0; i < rs_depth; i++) begin
            if (line_ready[i] && !rdy_found) begin
                sel_slot      = slot[i];
                line_clear[i] = alu_found; // freed only when it really goes
                rdy_found     = 1'b1;
            end
        end
    end

    assign fire = rdy_found && alu_found;

    always_comb begin
        for (int a = 0; a < num_alu; a++) begin
            issue[a]       = sel_slot;
            issue[a].valid = fire && alu_pick[a];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= fire; // one credit per issued line
        end
    end

endmodule

//--- logic/alu_unit.sv
module alu_unit (
    input  logic              clock,
    input  logic              reset,
    input  issue_pkg::issue_t issue,
    input  logic              grant,
    output logic              busy,
    output logic              req,
    output issue_pkg::cdb_t   result
);
    import issue_pkg::*;

    logic             ex_valid;
    issue_t           ex_q;
    logic             res_valid;
    logic [tag_w-1:0] res_tag;
    logic [xlen-1:0]  res_data;
    logic             res_take;

    // result slot frees up in the cycle its broadcast is granted
    assign res_take = ex_valid && (!res_valid || grant);

    always_ff @(posedge clock) begin
        if (reset) begin
            ex_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            ex_valid <= issue.valid;
            if (!res_valid || grant) begin
                res_valid <= ex_valid;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (issue.valid) begin
            ex_q <= issue;
        end
        if (res_take) begin
            res_data <= alu_compute(ex_q.op, ex_q.opa, ex_q.opb);
            res_tag  <= ex_q.dest_tag;
        end
    end

    assign busy = ex_valid || res_valid; // no new issue until broadcast
    assign req  = res_valid;

    always_comb begin
        result.valid = res_valid;
        result.tag   = res_tag;
        result.data  = res_data;
    end

endmodule

//--- logic/cdb_arbiter.sv
module cdb_arbiter #(
    parameter int num_alu  = 3,
    parameter int cdb_ways = 2
) (
    input  logic               clock,
    input  logic               reset,
    input  logic [num_alu-1:0] req,
    input  issue_pkg::cdb_t    result [num_alu],
    output logic [num_alu-1:0] grant,
    output issue_pkg::cdb_t    cdb [cdb_ways]
);
    import issue_pkg::*;

    localparam int ptr_w = (num_alu > 1) ? $clog2(num_alu) : 1;

    logic [ptr_w-1:0] ptr;
    logic [ptr_w-1:0] ptr_nxt;
    int               idx;
    int               used;

    // walk requesters from ptr, filling ways in order
    always_comb begin
        grant   = '0;
        ptr_nxt = ptr;
        used    = 0;
        idx     = 0;
        for (int w = 0; w < cdb_ways; w++) begin
            cdb[w] = '0;
        end
        for (int k = 0; k < num_alu; k++) begin
            idx = int'(ptr) + k;
            if (idx >= num_alu) begin
                idx = idx - num_alu; // wrap
            end
            if (req[idx] && used < cdb_ways) begin
                grant[idx] = 1'b1;
                cdb[used]  = result[idx];
                used       = used + 1;
                ptr_nxt    = (idx == num_alu - 1) ? '0 : ptr_w'(idx + 1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ptr <= '0;
        end else begin
            ptr <= ptr_nxt; // past last granted
        end
    end

endmodule

//--- logic/issue_core.sv
module issue_core #(
    parameter int rs_depth = 8,
    parameter int num_alu  = 3,
    parameter int cdb_ways = 2
) (
    input  logic                 clock,
    input  logic                 reset,
    input  issue_pkg::dispatch_t dispatch,
    output logic                 credit_return,
    output issue_pkg::cdb_t      cdb [cdb_ways]
);
    import issue_pkg::*;

    issue_t             issue [num_alu];
    cdb_t               alu_result [num_alu];
    logic [num_alu-1:0] alu_busy;
    logic [num_alu-1:0] alu_req;
    logic [num_alu-1:0] alu_grant;

    rs_bank #(
        .rs_depth (rs_depth),
        .num_alu  (num_alu),
        .cdb_ways (cdb_ways)
    ) i_rs_bank (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .cdb           (cdb),
        .alu_busy      (alu_busy),
        .issue         (issue),
        .credit_return (credit_return)
    );

    for (genvar a = 0; a < num_alu; a++) begin : g_alu
        alu_unit i_alu_unit (
            .clock  (clock),
            .reset  (reset),
            .issue  (issue[a]),
            .grant  (alu_grant[a]),
            .busy   (alu_busy[a]),
            .req    (alu_req[a]),
            .result (alu_result[a])
        );
    end

    cdb_arbiter #(
        .num_alu  (num_alu),
        .cdb_ways (cdb_ways)
    ) i_cdb_arbiter (
        .clock  (clock),
        .reset  (reset),
        .req    (alu_req),
        .result (alu_result),
        .grant  (alu_grant),
        .cdb    (cdb)
    );

endmodule

//--- tb/tb_clock.sv
module tb_clock #(
    parameter int half_period = 4
) (
    output logic clock
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock; // 8 ns period
    end

endmodule

//--- tb/issue_core_chk.sv
module issue_core_chk #(
    parameter int num_alu  = 3,
    parameter int cdb_ways = 2
) (
    input logic               clock,
    input logic               reset,
    input logic [num_alu-1:0] req,
    input logic [num_alu-1:0] grant,
    input issue_pkg::cdb_t    cdb [cdb_ways]
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0; // assertion failures so far

    assert property (@(posedge clock) disable iff (reset) (grant & ~req) == '0)
    else begin
        $error("grant given to an ALU that did not request");
        fail_count++;
    end

    assert property (@(posedge clock) disable iff (reset) $countones(grant) <= cdb_ways)
    else begin
        $error("more grants than CDB ways");
        fail_count++;
    end

    // every pair of ways
    for (genvar i = 0; i < cdb_ways; i++) begin : g_way
        for (genvar j = i + 1; j < cdb_ways; j++) begin : g_pair
            assert property (@(posedge clock) disable iff (reset)
                !(cdb[i].valid && cdb[j].valid && cdb[i].tag == cdb[j].tag))
            else begin
                $error("same tag broadcast on two CDB ways");
                fail_count++;
            end
        end
    end

endmodule

bind issue_core issue_core_chk #(
    .num_alu  (num_alu),
    .cdb_ways (cdb_ways)
) i_issue_core_chk (
    .clock (clock),
    .reset (reset),
    .req   (alu_req),
    .grant (alu_grant),
    .cdb   (cdb)
);

//--- tb/issue_core_tb.sv
module issue_core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import issue_pkg::*;

    localparam int rs_depth  = 8;
    localparam int num_alu   = 3;
    localparam int cdb_ways  = 2;
    localparam int total_ops = 108;

    logic             clock;
    logic             reset;
    dispatch_t        dispatch;
    logic             credit_return;
    cdb_t             cdb [cdb_ways];
    logic [31:0]      seed = 32'h3229_7057;
    logic [xlen-1:0]  exp_val [2**tag_w];
    logic             exp_pend [2**tag_w] = '{default: 1'b0};
    logic [tag_w-1:0] next_tag = '0;
    logic [tag_w-1:0] recent [$];
    int               credits = rs_depth;
    int               pending = 0;
    int               credits_back = 0;
    int               broadcasts = 0;
    int               errors = 0;
    int               tests_run = 0;
    int               tests_failed = 0;

    tb_clock i_tb_clock (.clock(clock));

    issue_core #(
        .rs_depth (rs_depth),
        .num_alu  (num_alu),
        .cdb_ways (cdb_ways)
    ) i_issue_core (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .credit_return (credit_return),
        .cdb           (cdb)
    );

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [xlen-1:0] model_result(alu_op_e op, logic [xlen-1:0] a,
                                                     logic [xlen-1:0] b);
        case (op)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            alu_sll: return a << b[4:0];
            default: return '0;
        endcase
    endfunction

    function automatic operand_t val_opnd(logic [xlen-1:0] v);
        operand_t o;
        o.is_value = 1'b1;
        o.val.data = v;
        return o;
    endfunction

    function automatic operand_t tag_opnd(logic [tag_w-1:0] t);
        operand_t o;
        o.is_value  = 1'b0;
        o.val.data  = '0;
        o.val.tv.tag = t;
        return o;
    endfunction

    function automatic logic [xlen-1:0] opnd_value(operand_t o);
        return o.is_value ? o.val.data : exp_val[o.val.tv.tag];
    endfunction

    function automatic logic [tag_w-1:0] alloc_tag();
        logic [tag_w-1:0] t;
        t = next_tag;
        next_tag = next_tag + 1'b1;
        return t;
    endfunction

    function automatic logic on_cdb(logic [tag_w-1:0] t);
        for (int w = 0; w < cdb_ways; w++) begin
            if (cdb[w].valid && cdb[w].tag == t) return 1'b1;
        end
        return 1'b0;
    endfunction

    // a recent tag still in flight, otherwise a plain value
    function automatic operand_t pick_operand();
        logic [31:0]      r;
        logic [tag_w-1:0] cand;
        r = next_rand();
        if (r[20] && recent.size() > 0) begin
            cand = recent[r[15:8] % recent.size()];
            if (exp_pend[cand]) return tag_opnd(cand);
        end
        return val_opnd(next_rand());
    endfunction

    task automatic wait_credit();
        while (credits == 0) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic send(alu_op_e op, operand_t a, operand_t b, logic [tag_w-1:0] tag);
        wait_credit();
        if (exp_pend[tag]) begin
            $display("error at %0t ns: tag %0d reused while still in flight", $time, tag);
            errors++;
        end else begin
            pending++;
        end
        exp_val[tag]      = model_result(op, opnd_value(a), opnd_value(b));
        exp_pend[tag]     = 1'b1;
        dispatch.valid    = 1'b1;
        dispatch.op       = op;
        dispatch.opa      = a;
        dispatch.opb      = b;
        dispatch.dest_tag = tag;
        credits--;
        @(posedge clock);
        #1;
        dispatch.valid = 1'b0;
    endtask

    // credits come back before the last broadcast, so all are in by now
    task automatic drain();
        while (pending != 0) begin
            @(posedge clock);
            #1;
        end
        if (credits != rs_depth) begin
            $display("error at %0t ns: %0d credits held after drain, expected %0d", $time,
                     credits, rs_depth);
            errors++;
        end
    endtask

    task automatic end_test(string name, int err_start);
        tests_run++;
        if (errors != err_start) begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_start);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // broadcast and credit monitor
    always @(negedge clock) begin
        if (!reset) begin
            if (credit_return) begin
                credits++;
                credits_back++;
            end
            for (int w = 0; w < cdb_ways; w++) begin
                if (cdb[w].valid) begin
                    broadcasts++;
                    if (!exp_pend[cdb[w].tag]) begin
                        $display("error at %0t ns: tag %0d broadcast but not expected",
                                 $time, cdb[w].tag);
                        errors++;
                    end else begin
                        if (cdb[w].data !== exp_val[cdb[w].tag]) begin
                            $display("error at %0t ns: tag %0d data %h, expected %h", $time,
                                     cdb[w].tag, cdb[w].data, exp_val[cdb[w].tag]);
                            errors++;
                        end
                        exp_pend[cdb[w].tag] = 1'b0;
                        pending--;
                    end
                end
            end
        end
    end

    task automatic test_reset();
        int err;
        err = errors;
        repeat (5) @(posedge clock);
        #1;
        for (int w = 0; w < cdb_ways; w++) begin
            if (cdb[w].valid) begin
                $display("error at %0t ns: cdb way %0d valid after reset", $time, w);
                errors++;
            end
        end
        if (credits_back != 0 || broadcasts != 0 || credits != rs_depth) begin
            $display("error at %0t ns: activity with nothing dispatched", $time);
            errors++;
        end
        end_test("reset", err);
    endtask

    task automatic test_independent();
        int err;
        err = errors;
        for (int i = 0; i < 6; i++) begin
            send(alu_op_e'(i), val_opnd(next_rand()), val_opnd(next_rand()), alloc_tag());
        end
        drain();
        end_test("independent", err);
    endtask

    task automatic test_chain();
        int               err;
        logic [tag_w-1:0] prev;
        logic [tag_w-1:0] cur;
        err  = errors;
        prev = alloc_tag();
        send(alu_add, val_opnd(next_rand()), val_opnd(next_rand()), prev);
        for (int i = 1; i < 8; i++) begin
            cur = alloc_tag();
            send(alu_op_e'(i % 6), tag_opnd(prev), val_opnd(next_rand()), cur);
            prev = cur;
        end
        prev = alloc_tag();
        send(alu_xor, val_opnd(next_rand()), val_opnd(next_rand()), prev);
        while (!on_cdb(prev)) begin
            @(posedge clock);
            #1;
        end
        cur = alloc_tag(); // loads on the producer's broadcast cycle
        send(alu_sub, val_opnd(next_rand()), tag_opnd(prev), cur);
        drain();
        end_test("chain", err);
    endtask

    task automatic test_credit_fill();
        int               err;
        int               back_start;
        logic [tag_w-1:0] prod;
        logic [xlen-1:0]  pa;
        logic [xlen-1:0]  pb;
        err        = errors;
        back_start = credits_back;
        prod       = alloc_tag();
        pa         = next_rand();
        pb         = next_rand();
        exp_val[prod] = model_result(alu_add, pa, pb); // consumers need it first
        for (int i = 0; i < rs_depth - 1; i++) begin
            send(alu_op_e'(i % 6), tag_opnd(prod), val_opnd(next_rand()), alloc_tag());
        end
        if (credits != 1) begin
            $display("error at %0t ns: %0d credits left, expected 1", $time, credits);
            errors++;
        end
        send(alu_add, val_opnd(pa), val_opnd(pb), prod);
        if (credits != 0 || credits_back != back_start) begin
            $display("error at %0t ns: bank full but %0d credits held", $time, credits);
            errors++;
        end
        drain();
        if (credits_back - back_start != rs_depth) begin
            $display("error at %0t ns: %0d credits returned, expected %0d", $time,
                     credits_back - back_start, rs_depth);
            errors++;
        end
        end_test("credit_fill", err);
    endtask

    task automatic test_contention();
        int err;
        err = errors;
        for (int i = 0; i < 24; i++) begin
            send(alu_op_e'(next_rand() % 6), val_opnd(next_rand()), val_opnd(next_rand()),
                 alloc_tag());
        end
        drain();
        end_test("contention", err);
    endtask

    task automatic test_random_mix();
        int               err;
        operand_t         a;
        operand_t         b;
        alu_op_e          op;
        logic [tag_w-1:0] t;
        err = errors;
        recent.delete();
        for (int i = 0; i < 60; i++) begin
            wait_credit(); // pick after the wait so a chosen tag is still pending
            op = alu_op_e'(next_rand() % 6);
            a  = pick_operand();
            b  = pick_operand();
            t  = alloc_tag();
            send(op, a, b, t);
            recent.push_back(t);
            if (recent.size() > 6) void'(recent.pop_front());
        end
        drain();
        end_test("random_mix", err);
    endtask

    initial begin
        repeat (total_ops * 40) @(posedge clock);
        $display("timeout: tests did not finish within %0d cycles", total_ops * 40);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset    = 1'b1;
        dispatch = '0;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        test_reset();
        test_independent();
        test_chain();
        test_credit_fill();
        test_contention();
        test_random_mix();
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d, broadcasts %0d",
                 tests_run, tests_failed, errors,
                 i_issue_core.i_issue_core_chk.fail_count, broadcasts);
        if (errors == 0 && i_issue_core.i_issue_core_chk.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tb.f
logic/issue_pkg.sv
logic/rs_line.sv
logic/rs_bank.sv
logic/alu_unit.sv
logic/cdb_arbiter.sv
logic/issue_core.sv
tb/tb_clock.sv
tb/issue_core_chk.sv
tb/issue_core_tb.sv
